// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = light_cycle_tb
FILELIST  = build.f
LOG       = sim.log
PASS_MSG  = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
verilog/cycle_pkg.sv
verilog/bike_motion.sv
verilog/arena.sv
verilog/trail_grid.sv
verilog/game_control.sv
verilog/light_cycle_top.sv
dv/light_cycle_properties.sv
dv/light_cycle_checker.sv
dv/light_cycle_tb.sv

// ==== dv/light_cycle_checker.sv ====
// light-cycle reference model: rebuilds bikes, trail map, state and winner, compares the DUT
module light_cycle_checker #(
    parameter int unsigned X_MIN        = 14,
    parameter int unsigned X_MAX        = 462,
    parameter int unsigned Y_MIN        = 14,
    parameter int unsigned Y_MAX        = 462,
    parameter int unsigned BIKE_SIZE    = 16,
    parameter int unsigned SPAWN_X_BLUE = 76,
    parameter int unsigned SPAWN_X_RED  = 400,
    parameter int unsigned SPAWN_Y      = 240
) (
    input  logic                   Clk,
    input  logic                   rst_n,
    input  logic                   frame_clk,
    input  logic [7:0]             keycode,
    input  cycle_pkg::bike_state_t blue,
    input  cycle_pkg::bike_state_t red,
    input  cycle_pkg::game_state_t state,
    input  cycle_pkg::winner_t     winner,
    input  logic                   check,
    input  logic                   exp_valid,
    input  cycle_pkg::game_state_t exp_state,
    input  cycle_pkg::winner_t     exp_winner,
    output int                     errors,
    output int                     checks
);
    timeunit 1ns;
    timeprecision 1ns;
    import cycle_pkg::*;

    bike_state_t   mb;
    bike_state_t   mr;
    game_state_t   ms;
    winner_t       mw;
    logic [127:0]  mvis [128];
    logic [13:0]   last_b;
    logic [13:0]   last_r;
    logic          frame_q;

    function automatic logic is_vertical(input heading_t h);
        return (h == HEAD_UP) || (h == HEAD_DOWN);
    endfunction

    // turn on an aligned coordinate unless it points back, then one pixel
    function automatic bike_state_t step_bike(input bike_state_t b, input logic [7:0] key,
                                              input logic is_red);
        heading_t want;
        logic     take;
        take = 1'b1;
        want = b.heading;
        if (key == (is_red ? KEY_UP : KEY_W))
            want = HEAD_UP;
        else if (key == (is_red ? KEY_DOWN : KEY_S))
            want = HEAD_DOWN;
        else if (key == (is_red ? KEY_LEFT : KEY_A))
            want = HEAD_LEFT;
        else if (key == (is_red ? KEY_RIGHT : KEY_D))
            want = HEAD_RIGHT;
        else
            take = 1'b0;
        if (is_vertical(want) && (b.x % 4 != 0))
            take = 1'b0;
        if (!is_vertical(want) && (b.y % 4 != 0))
            take = 1'b0;
        // same axis but a different heading is a U-turn
        if (want != b.heading && is_vertical(want) == is_vertical(b.heading))
            take = 1'b0;
        if (take)
            b.heading = want;
        case (b.heading)
            HEAD_UP:    b.y = b.y - 1;
            HEAD_DOWN:  b.y = b.y + 1;
            HEAD_LEFT:  b.x = b.x - 1;
            default:    b.x = b.x + 1;
        endcase
        return b;
    endfunction

    function automatic logic reached_wall(input bike_state_t b);
        int x;
        int y;
        x = b.x;
        y = b.y;
        return (x >= int'(X_MAX - BIKE_SIZE)) || (x <= int'(X_MIN + BIKE_SIZE)) ||
               (y >= int'(Y_MAX - BIKE_SIZE)) || (y <= int'(Y_MIN + BIKE_SIZE));
    endfunction

    function automatic logic [13:0] cell_of(input bike_state_t b);
        return {CELL_W'(b.y >> 2), CELL_W'(b.x >> 2)};
    endfunction

    // ------------------------------------------------------------------
    // model updates
    // ------------------------------------------------------------------
    task automatic new_round();
        mb = '{x: POS_W'(SPAWN_X_BLUE), y: POS_W'(SPAWN_Y), heading: HEAD_RIGHT};
        mr = '{x: POS_W'(SPAWN_X_RED), y: POS_W'(SPAWN_Y), heading: HEAD_LEFT};
        for (int i = 0; i < 128; i++)
            mvis[i] = '0;
        last_b = '0;
        last_r = '0;
        mw     = WIN_NONE;
    endtask

    task automatic advance_model();
        bike_state_t nb;
        bike_state_t nr;
        logic [13:0] cb;
        logic [13:0] cr;
        logic        hb;
        logic        hr;
        nb = step_bike(mb, keycode, 1'b0);
        nr = step_bike(mr, keycode, 1'b1);
        cb = cell_of(nb);
        cr = cell_of(nr);
        // leaving the own cell into a marked one, or meeting in one cell
        hb = (cb == cr) || (cb != last_b && mvis[cb[13:7]][cb[6:0]]);
        hr = (cb == cr) || (cr != last_r && mvis[cr[13:7]][cr[6:0]]);
        hb = hb || reached_wall(nb);
        hr = hr || reached_wall(nr);
        mvis[cb[13:7]][cb[6:0]] = 1'b1;
        mvis[cr[13:7]][cr[6:0]] = 1'b1;
        last_b = cb;
        last_r = cr;
        mb     = nb;
        mr     = nr;
        if (hb || hr)
        begin
            ms = ST_OVER;
            mw = (hb && hr) ? WIN_DRAW : (hb ? WIN_RED : WIN_BLUE);
        end
    endtask

    task automatic compare_field(input string name, input int got, input int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("FAILED at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------------
    // watch and compare
    // ------------------------------------------------------------------
    initial
    begin
        errors = 0;
        checks = 0;
    end

    always @(posedge Clk)
    begin
        if (!rst_n)
        begin
            new_round();
            ms      = ST_IDLE;
            frame_q = 1'b0;
        end
        else
        begin
            if (check)
            begin
                compare_field("blue.x", blue.x, mb.x);
                compare_field("blue.y", blue.y, mb.y);
                compare_field("blue.heading", int'(blue.heading), int'(mb.heading));
                compare_field("red.x", red.x, mr.x);
                compare_field("red.y", red.y, mr.y);
                compare_field("red.heading", int'(red.heading), int'(mr.heading));
                compare_field("state", int'(state), int'(ms));
                compare_field("winner", int'(winner), int'(mw));
                if (exp_valid)
                begin
                    compare_field("state (table)", int'(state), int'(exp_state));
                    compare_field("winner (table)", int'(winner), int'(exp_winner));
                end
            end
            if ((ms == ST_IDLE || ms == ST_OVER) && keycode == KEY_SPACE)
            begin
                new_round();
                ms = ST_PLAY;
            end
            else if (ms == ST_PLAY && frame_clk && !frame_q)
            begin
                advance_model();
            end
            frame_q = frame_clk;
        end
    end

endmodule

// ==== dv/light_cycle_properties.sv ====
// light-cycle bound assertions: frame strobe width, winner in play, bikes parked
module light_cycle_properties (
    input logic                   Clk,
    input logic                   rst_n,
    input logic                   tick,
    input cycle_pkg::game_state_t state,
    input cycle_pkg::winner_t     winner,
    input cycle_pkg::bike_state_t blue,
    input cycle_pkg::bike_state_t red
);
    timeunit 1ns;
    timeprecision 1ns;
    import cycle_pkg::*;

    // frame strobe is a single-cycle pulse
    tick_single: assert property (@(posedge Clk) disable iff (!rst_n) tick |=> !tick)
        else $error("tick high on two consecutive cycles");

    // no result while a round runs
    no_winner_in_play: assert property (@(posedge Clk) disable iff (!rst_n)
        state == ST_PLAY |-> winner == WIN_NONE)
        else $error("winner set while state is play");

    // only spawn reloads and only play moves
    parked: assert property (@(posedge Clk) disable iff (!rst_n)
        (state == ST_IDLE || state == ST_OVER) |=> ($stable(blue) && $stable(red)))
        else $error("bike moved outside play");

endmodule

bind light_cycle_top light_cycle_properties u_props (
    .Clk(Clk), .rst_n(rst_n), .tick(tick), .state(state),
    .winner(winner), .blue(blue), .red(red)
);

// ==== dv/light_cycle_tb.sv ====
// light-cycle testbench driving the game core through a table of keys and frames
module light_cycle_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import cycle_pkg::*;

    localparam int NUM_ROWS     = 14;
    localparam int MAX_FILLER   = 2;
    // one frame_clk pulse cycle plus 8 quiet cycles
    localparam int FRAME_CYCLES = 9;

    // one table row holds the key, the frames to run and an optional checkpoint
    typedef struct packed {
        logic [7:0]  key;
        logic [15:0] frames;
        logic        chk;
        logic        has_exp;
        game_state_t exp_state;
        winner_t     exp_winner;
    } row_t;

    logic        Clk;
    logic        rst_n;
    logic        frame_clk;
    logic [7:0]  keycode;
    bike_state_t blue;
    bike_state_t red;
    game_state_t state;
    winner_t     winner;
    logic        check;
    logic        exp_valid;
    game_state_t exp_state;
    winner_t     exp_winner;
    int          errors;
    int          checks;
    row_t        stim [NUM_ROWS];
    int          limit;
    int          cycles;

    light_cycle_top #(
        .X_MIN(14), .X_MAX(462), .Y_MIN(14), .Y_MAX(462), .BIKE_SIZE(16),
        .SPAWN_X_BLUE(76), .SPAWN_X_RED(400), .SPAWN_Y(240)
    ) UUT (
        .Clk(Clk), .rst_n(rst_n), .frame_clk(frame_clk), .keycode(keycode),
        .blue(blue), .red(red), .state(state), .winner(winner)
    );

    light_cycle_checker #(
        .X_MIN(14), .X_MAX(462), .Y_MIN(14), .Y_MAX(462), .BIKE_SIZE(16),
        .SPAWN_X_BLUE(76), .SPAWN_X_RED(400), .SPAWN_Y(240)
    ) u_check (
        .Clk(Clk), .rst_n(rst_n), .frame_clk(frame_clk), .keycode(keycode),
        .blue(blue), .red(red), .state(state), .winner(winner),
        .check(check), .exp_valid(exp_valid), .exp_state(exp_state),
        .exp_winner(exp_winner), .errors(errors), .checks(checks)
    );

    initial
    begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    // ------------------------------------------------------------------
    // stimulus table
    // ------------------------------------------------------------------
    task automatic load_table();
        // round 1 runs straight, ignores reverse keys, turns and drives blue up into the top wall
        stim[0]  = '{KEY_SPACE, 16'd0, 1'b1, 1'b1, ST_PLAY, WIN_NONE};
        stim[1]  = '{8'h00, 16'd3, 1'b1, 1'b1, ST_PLAY, WIN_NONE};
        stim[2]  = '{KEY_A, 16'd2, 1'b1, 1'b1, ST_PLAY, WIN_NONE};
        stim[3]  = '{KEY_RIGHT, 16'd2, 1'b1, 1'b1, ST_PLAY, WIN_NONE};
        stim[4]  = '{KEY_S, 16'd6, 1'b1, 1'b1, ST_PLAY, WIN_NONE};
        stim[5]  = '{KEY_D, 16'd5, 1'b1, 1'b1, ST_PLAY, WIN_NONE};
        stim[6]  = '{KEY_W, 16'd250, 1'b1, 1'b1, ST_OVER, WIN_RED};
        // round 2 loops red down, left, up and right back across its own trail
        stim[7]  = '{KEY_SPACE, 16'd0, 1'b1, 1'b1, ST_PLAY, WIN_NONE};
        stim[8]  = '{KEY_DOWN, 16'd16, 1'b1, 1'b1, ST_PLAY, WIN_NONE};
        // mid-loop positions against the model only
        stim[9]  = '{KEY_LEFT, 16'd4, 1'b1, 1'b0, ST_PLAY, WIN_NONE};
        stim[10] = '{KEY_UP, 16'd4, 1'b1, 1'b1, ST_PLAY, WIN_NONE};
        stim[11] = '{KEY_RIGHT, 16'd16, 1'b1, 1'b1, ST_OVER, WIN_BLUE};
        // round 3 rides blue over cells of round 2 on a cleared map
        stim[12] = '{KEY_SPACE, 16'd0, 1'b1, 1'b1, ST_PLAY, WIN_NONE};
        stim[13] = '{8'h00, 16'd30, 1'b1, 1'b1, ST_PLAY, WIN_NONE};
    endtask

    // called and returns on a falling edge
    task automatic run_frame();
        frame_clk = 1'b1;
        @(negedge Clk);
        frame_clk = 1'b0;
        repeat (FRAME_CYCLES - 1) @(negedge Clk);
    endtask

    task automatic checkpoint(input logic has_exp, input game_state_t st, input winner_t win);
        exp_valid  = has_exp;
        exp_state  = st;
        exp_winner = win;
        check      = 1'b1;
        @(negedge Clk);
        check = 1'b0;
    endtask

    task automatic apply_row(input row_t row);
        keycode = row.key;
        // a start key needs no frame since spawn and play follow within two cycles
        if (row.frames == 0)
            repeat (4) @(negedge Clk);
        else
            repeat (row.frames) run_frame();
        if (row.chk)
            checkpoint(row.has_exp, row.exp_state, row.exp_winner);
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------
    initial
    begin
        int filler;
        rst_n      = 1'b0;
        frame_clk  = 1'b0;
        keycode    = 8'h00;
        check      = 1'b0;
        exp_valid  = 1'b0;
        exp_state  = ST_IDLE;
        exp_winner = WIN_NONE;
        load_table();
        limit = 200;
        for (int r = 0; r < NUM_ROWS; r++)
            limit += (stim[r].frames + MAX_FILLER + 1) * FRAME_CYCLES;
        void'($urandom(9705));
        repeat (3) @(negedge Clk);
        rst_n = 1'b1;
        @(negedge Clk);
        // idle after reset with bikes parked on spawn
        checkpoint(1'b1, ST_IDLE, WIN_NONE);
        for (int r = 0; r < NUM_ROWS; r++)
        begin
            apply_row(stim[r]);
            if (r < NUM_ROWS - 1)
            begin
                filler  = $urandom_range(MAX_FILLER, 0);
                keycode = 8'h00;
                repeat (filler) run_frame();
            end
        end
        repeat (2) @(negedge Clk);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // run limit from the table length
    initial
    begin
        cycles = 0;
        forever
        begin
            @(posedge Clk);
            cycles++;
            if (cycles > limit)
            begin
                $display("timeout: run did not finish within %0d cycles", limit);
                $display("Test failures found");
                $finish;
            end
        end
    end

endmodule

// ==== verilog/arena.sv ====
// playing field: frame edge detect, both bikes and the wall test
module arena #(
    parameter int unsigned X_MIN        = 14,
    parameter int unsigned X_MAX        = 462,
    parameter int unsigned Y_MIN        = 14,
    parameter int unsigned Y_MAX        = 462,
    parameter int unsigned BIKE_SIZE    = 16,
    parameter int unsigned SPAWN_X_BLUE = 76,
    parameter int unsigned SPAWN_X_RED  = 400,
    parameter int unsigned SPAWN_Y      = 240
) (
    input  logic                   Clk,
    input  logic                   rst_n,
    input  logic                   frame_clk,
    input  logic [7:0]             keycode,
    input  cycle_pkg::game_state_t state,
    output cycle_pkg::bike_state_t blue,
    output cycle_pkg::bike_state_t red,
    output logic                   tick,
    output logic [1:0]             wall_hit
);
    import cycle_pkg::*;

    logic frame_sync;
    logic frame_prev;
    logic load;
    logic advance;

    // bike body touches or crosses any of the four walls
    function automatic logic at_wall(input bike_state_t b);
        at_wall = (b.x + BIKE_SIZE >= X_MAX) || (b.x <= X_MIN + BIKE_SIZE) ||
                  (b.y + BIKE_SIZE >= Y_MAX) || (b.y <= Y_MIN + BIKE_SIZE);
    endfunction

    // ------------------------------------------------------------------
    // frame strobe
    // ------------------------------------------------------------------

    // frame_clk is slow, one register then a registered rise detect
    always_ff @(posedge Clk)
    begin
        if (!rst_n)
        begin
            frame_sync <= 1'b0;
            frame_prev <= 1'b0;
            tick       <= 1'b0;
        end
        else
        begin
            frame_sync <= frame_clk;
            frame_prev <= frame_sync;
            tick       <= frame_sync && !frame_prev;
        end
    end

    assign load    = (state == ST_SPAWN);
    assign advance = tick && (state == ST_PLAY);

    // blue starts on the left heading right, red on the right heading left
    bike_motion #(
        .SPAWN_X(SPAWN_X_BLUE), .SPAWN_Y(SPAWN_Y), .SPAWN_HEADING(HEAD_RIGHT),
        .KEY_UP_CODE(KEY_W), .KEY_DOWN_CODE(KEY_S),
        .KEY_LEFT_CODE(KEY_A), .KEY_RIGHT_CODE(KEY_D)
    ) u_blue (
        .Clk(Clk), .rst_n(rst_n), .load(load), .advance(advance),
        .keycode(keycode), .bike(blue)
    );

    bike_motion #(
        .SPAWN_X(SPAWN_X_RED), .SPAWN_Y(SPAWN_Y), .SPAWN_HEADING(HEAD_LEFT),
        .KEY_UP_CODE(KEY_UP), .KEY_DOWN_CODE(KEY_DOWN),
        .KEY_LEFT_CODE(KEY_LEFT), .KEY_RIGHT_CODE(KEY_RIGHT)
    ) u_red (
        .Clk(Clk), .rst_n(rst_n), .load(load), .advance(advance),
        .keycode(keycode), .bike(red)
    );

    // bit 0 blue, bit 1 red; follows the moved positions one cycle later
    always_ff @(posedge Clk)
    begin
        if (!rst_n || load)
            wall_hit <= 2'b00;
        else
            wall_hit <= {at_wall(red), at_wall(blue)};
    end

endmodule

// ==== verilog/bike_motion.sv ====
// single bike: position register, heading and turns limited to the 4-pixel grid
module bike_motion #(
    parameter int unsigned         SPAWN_X        = 76,
    parameter int unsigned         SPAWN_Y        = 240,
    parameter cycle_pkg::heading_t SPAWN_HEADING  = cycle_pkg::HEAD_RIGHT,
    parameter logic [7:0]          KEY_UP_CODE    = cycle_pkg::KEY_W,
    parameter logic [7:0]          KEY_DOWN_CODE  = cycle_pkg::KEY_S,
    parameter logic [7:0]          KEY_LEFT_CODE  = cycle_pkg::KEY_A,
    parameter logic [7:0]          KEY_RIGHT_CODE = cycle_pkg::KEY_D
) (
    input  logic                   Clk,
    input  logic                   rst_n,
    input  logic                   load,
    input  logic                   advance,
    input  logic [7:0]             keycode,
    output cycle_pkg::bike_state_t bike
);
    import cycle_pkg::*;

    heading_t    key_heading;
    logic        key_valid;
    logic        aligned;
    logic        reverse;
    heading_t    heading_next;
    bike_state_t bike_next;

    // heading that points straight back
    function automatic heading_t opposite(input heading_t h);
        case (h)
            HEAD_UP:   opposite = HEAD_DOWN;
            HEAD_DOWN: opposite = HEAD_UP;
            HEAD_LEFT: opposite = HEAD_RIGHT;
            default:   opposite = HEAD_LEFT;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // turn request
    // ------------------------------------------------------------------

    // only this rider's four keys count, anything else is no request
    always_comb
    begin
        key_valid   = 1'b1;
        key_heading = bike.heading;
        case (keycode)
            KEY_UP_CODE:    key_heading = HEAD_UP;
            KEY_DOWN_CODE:  key_heading = HEAD_DOWN;
            KEY_LEFT_CODE:  key_heading = HEAD_LEFT;
            KEY_RIGHT_CODE: key_heading = HEAD_RIGHT;
            default:        key_valid = 1'b0;
        endcase
    end

    // vertical turn needs x on the grid, horizontal turn needs y on it
    always_comb
    begin
        if (key_heading == HEAD_UP || key_heading == HEAD_DOWN)
            aligned = (bike.x[1:0] == 2'b00);
        else
            aligned = (bike.y[1:0] == 2'b00);
    end

    // a U-turn would drive straight into the own trail
    assign reverse = (key_heading == opposite(bike.heading));

    assign heading_next = (key_valid && aligned && !reverse) ? key_heading : bike.heading;

    // ------------------------------------------------------------------
    // step
    // ------------------------------------------------------------------

    // one pixel along the heading chosen in this same step
    always_comb
    begin
        bike_next         = bike;
        bike_next.heading = heading_next;
        case (heading_next)
            HEAD_UP:   bike_next.y = bike.y - 1'b1;
            HEAD_DOWN: bike_next.y = bike.y + 1'b1;
            HEAD_LEFT: bike_next.x = bike.x - 1'b1;
            default:   bike_next.x = bike.x + 1'b1;
        endcase
    end

    // reset and load both put the bike back on its spawn point
    always_ff @(posedge Clk)
    begin
        if (!rst_n || load)
        begin
            bike.x       <= POS_W'(SPAWN_X);
            bike.y       <= POS_W'(SPAWN_Y);
            bike.heading <= SPAWN_HEADING;
        end
        else if (advance)
        begin
            bike <= bike_next;
        end
    end

endmodule

// ==== verilog/cycle_pkg.sv ====
// light-cycle shared definitions: bike state, game-state encoding, key scan codes
package cycle_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------

    // pixel coordinate width
    localparam int POS_W = 10;
    // grid cell index width, a cell is 4 by 4 pixels
    localparam int CELL_W = 7;

    // ------------------------------------------------------------------
    // types
    // ------------------------------------------------------------------

    // direction of travel
    typedef enum logic [1:0] {
        HEAD_UP,
        HEAD_DOWN,
        HEAD_LEFT,
        HEAD_RIGHT
    } heading_t;

    // one bike, 22 bits
    typedef struct packed {
        logic [POS_W-1:0] x;
        logic [POS_W-1:0] y;
        heading_t         heading;
    } bike_state_t;

    // spawn and play keep the legacy encoding 1 and 2
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_SPAWN = 3'd1,
        ST_PLAY  = 3'd2,
        ST_OVER  = 3'd3
    } game_state_t;

    typedef enum logic [1:0] {
        WIN_NONE,
        WIN_BLUE,
        WIN_RED,
        WIN_DRAW
    } winner_t;

    // ------------------------------------------------------------------
    // keyboard scan codes
    // ------------------------------------------------------------------

    // blue rider, WASD
    localparam logic [7:0] KEY_W = 8'h1A;
    localparam logic [7:0] KEY_A = 8'h04;
    localparam logic [7:0] KEY_S = 8'h16;
    localparam logic [7:0] KEY_D = 8'h07;
    // red rider, arrow keys
    localparam logic [7:0] KEY_UP    = 8'h52;
    localparam logic [7:0] KEY_LEFT  = 8'h50;
    localparam logic [7:0] KEY_DOWN  = 8'h51;
    localparam logic [7:0] KEY_RIGHT = 8'h4F;
    // starts a round from idle or over
    localparam logic [7:0] KEY_SPACE = 8'h2C;

endpackage

// ==== verilog/game_control.sv ====
// game FSM: idle, spawn, play and over, with the winner decision on a crash
module game_control (
    input  logic                   Clk,
    input  logic                   rst_n,
    input  logic [7:0]             keycode,
    input  logic [1:0]             wall_hit,
    input  logic [1:0]             trail_hit,
    output cycle_pkg::game_state_t state,
    output cycle_pkg::winner_t     winner
);
    import cycle_pkg::*;

    logic [1:0]  hit;
    logic        start;
    game_state_t state_next;
    winner_t     winner_next;

    // bit 0 blue, bit 1 red, from either source
    assign hit   = wall_hit | trail_hit;
    assign start = (keycode == KEY_SPACE);

    // ------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------
    always_comb
    begin
        state_next  = state;
        winner_next = winner;
        case (state)
            ST_IDLE:
            begin
                if (start)
                    state_next = ST_SPAWN;
            end
            ST_SPAWN:
            begin
                // one cycle to reload bikes and clear the map
                state_next  = ST_PLAY;
                winner_next = WIN_NONE;
            end
            ST_PLAY:
            begin
                if (hit != 2'b00)
                begin
                    state_next = ST_OVER;
                    // the one who did not crash wins
                    case (hit)
                        2'b01:   winner_next = WIN_RED;
                        2'b10:   winner_next = WIN_BLUE;
                        default: winner_next = WIN_DRAW;
                    endcase
                end
            end
            ST_OVER:
            begin
                if (start)
                    state_next = ST_SPAWN;
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge Clk)
    begin
        if (!rst_n)
        begin
            state  <= ST_IDLE;
            winner <= WIN_NONE;
        end
        else
        begin
            state  <= state_next;
            winner <= winner_next;
        end
    end

endmodule

// ==== verilog/light_cycle_top.sv ====
// light-cycle game core: arena with both bikes, trail map and game FSM
module light_cycle_top #(
    parameter int unsigned X_MIN        = 14,
    parameter int unsigned X_MAX        = 462,
    parameter int unsigned Y_MIN        = 14,
    parameter int unsigned Y_MAX        = 462,
    parameter int unsigned BIKE_SIZE    = 16,
    parameter int unsigned SPAWN_X_BLUE = 76,
    parameter int unsigned SPAWN_X_RED  = 400,
    parameter int unsigned SPAWN_Y      = 240
) (
    input  logic                   Clk,
    input  logic                   rst_n,
    input  logic                   frame_clk,
    input  logic [7:0]             keycode,
    output cycle_pkg::bike_state_t blue,
    output cycle_pkg::bike_state_t red,
    output cycle_pkg::game_state_t state,
    output cycle_pkg::winner_t     winner
);

    // frame strobe, positions advance on it
    logic       tick;
    // bit 0 blue, bit 1 red
    logic [1:0] wall_hit;
    logic [1:0] trail_hit;

    arena #(
        .X_MIN(X_MIN), .X_MAX(X_MAX), .Y_MIN(Y_MIN), .Y_MAX(Y_MAX),
        .BIKE_SIZE(BIKE_SIZE), .SPAWN_X_BLUE(SPAWN_X_BLUE),
        .SPAWN_X_RED(SPAWN_X_RED), .SPAWN_Y(SPAWN_Y)
    ) u_arena (
        .Clk(Clk), .rst_n(rst_n), .frame_clk(frame_clk), .keycode(keycode),
        .state(state), .blue(blue), .red(red), .tick(tick), .wall_hit(wall_hit)
    );

    trail_grid u_trail (
        .Clk(Clk), .rst_n(rst_n), .state(state), .tick(tick),
        .blue(blue), .red(red), .trail_hit(trail_hit)
    );

    game_control u_ctrl (
        .Clk(Clk), .rst_n(rst_n), .keycode(keycode), .wall_hit(wall_hit),
        .trail_hit(trail_hit), .state(state), .winner(winner)
    );

endmodule

// ==== verilog/trail_grid.sv ====
// trail map: one bit per 4x4 cell visited this round, and trail collision test
module trail_grid (
    input  logic                   Clk,
    input  logic                   rst_n,
    input  cycle_pkg::game_state_t state,
    input  logic                   tick,
    input  cycle_pkg::bike_state_t blue,
    input  cycle_pkg::bike_state_t red,
    output logic [1:0]             trail_hit
);
    import cycle_pkg::*;

    // 480 pixels across, 120 cells
    localparam int GRID_N = 120;

    logic [GRID_N-1:0]   visited [GRID_N];
    logic                tick_d;
    logic                update;
    logic [CELL_W-1:0]   blue_cx;
    logic [CELL_W-1:0]   blue_cy;
    logic [CELL_W-1:0]   red_cx;
    logic [CELL_W-1:0]   red_cy;
    logic [2*CELL_W-1:0] blue_last;
    logic [2*CELL_W-1:0] red_last;
    logic                same_cell;
    logic [1:0]          hit_next;

    // cell index is the pixel position over 4
    assign blue_cx = CELL_W'(blue.x >> 2);
    assign blue_cy = CELL_W'(blue.y >> 2);
    assign red_cx  = CELL_W'(red.x >> 2);
    assign red_cy  = CELL_W'(red.y >> 2);

    // positions move on the tick edge, so the map looks one cycle later
    always_ff @(posedge Clk)
    begin
        if (!rst_n)
            tick_d <= 1'b0;
        else
            tick_d <= tick;
    end

    assign update = tick_d && (state == ST_PLAY);

    // ------------------------------------------------------------------
    // collision test
    // ------------------------------------------------------------------

    // head-on into one cell takes both bikes out
    assign same_cell = ({blue_cy, blue_cx} == {red_cy, red_cx});

    // staying inside the current cell is not a hit, a bike needs 4 steps to leave it
    assign hit_next[0] = same_cell ||
                         (({blue_cy, blue_cx} != blue_last) && visited[blue_cy][blue_cx]);
    assign hit_next[1] = same_cell ||
                         (({red_cy, red_cx} != red_last) && visited[red_cy][red_cx]);

    // map cleared for a new round, then both cells marked on every update
    always_ff @(posedge Clk)
    begin
        if (!rst_n || state == ST_SPAWN)
        begin
            for (int row = 0; row < GRID_N; row++)
                visited[row] <= '0;
            blue_last <= '0;
            red_last  <= '0;
            trail_hit <= 2'b00;
        end
        else if (update)
        begin
            visited[blue_cy][blue_cx] <= 1'b1;
            visited[red_cy][red_cx]   <= 1'b1;
            blue_last <= {blue_cy, blue_cx};
            red_last  <= {red_cy, red_cx};
            // held until the next update or spawn
            trail_hit <= hit_next;
        end
    end

endmodule
